// ==== Bender.yml ====
package:
  name: mandel_renderer

sources:
  - hdl/mandel_pkg.sv
  - hdl/point_job_if.sv
  - hdl/raster_counter.sv
  - hdl/frame_sequencer.sv
  - hdl/coord_mapper.sv
  - hdl/escape_core.sv
  - hdl/mandel_renderer.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/mandel_renderer_tb.sv

// ==== hdl/coord_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module coord_mapper
    import mandel_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       map_start,
    input  pix_x_t     map_x,
    input  pix_y_t     map_y,
    input  view_e      view,
    point_job_if.mapper job
);

    fix_t  x_min, x_max, y_min, y_max;
    wide_t re_prod;         // Range times pixel, stage one
    wide_t im_prod;
    logic  prod_valid;

    always_comb begin
        case (view)
            VIEW_FULL:     {x_min, x_max, y_min, y_max} =
                {FULL_X_MIN, FULL_X_MAX, FULL_Y_MIN, FULL_Y_MAX};
            VIEW_SEAHORSE: {x_min, x_max, y_min, y_max} =
                {SEAHORSE_X_MIN, SEAHORSE_X_MAX, SEAHORSE_Y_MIN, SEAHORSE_Y_MAX};
            VIEW_ELEPHANT: {x_min, x_max, y_min, y_max} =
                {ELEPHANT_X_MIN, ELEPHANT_X_MAX, ELEPHANT_Y_MIN, ELEPHANT_Y_MAX};
            default:       {x_min, x_max, y_min, y_max} =
                {DEEP_TAIL_X_MIN, DEEP_TAIL_X_MAX, DEEP_TAIL_Y_MIN, DEEP_TAIL_Y_MAX};
        endcase
    end

    // Stage one, multiply
    always_ff @(posedge clk) begin
        if (map_start) begin
            re_prod <= wide_t'(fix_t'(x_max - x_min)) * wide_t'(map_x);
            im_prod <= wide_t'(fix_t'(y_max - y_min)) * wide_t'(map_y);
        end
    end

    // Stage two, signed divide by the pixel span and offset by the minimum
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            job.c_re <= x_min + fix_t'(re_prod / wide_t'(FRAME_W - 1));
            job.c_im <= y_min + fix_t'(im_prod / wide_t'(FRAME_H - 1));
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            prod_valid <= 1'b0;
            job.valid  <= 1'b0;
        end else begin
            prod_valid <= map_start;
            if (prod_valid) begin
                job.valid <= 1'b1;
            end else if (job.ready) begin
                job.valid <= 1'b0;  // Taken by the core
            end
        end
    end

    a_job_held: assert property (@(posedge clk) disable iff (!resetn)
        job.valid && !job.ready |=> job.valid && $stable({job.c_re, job.c_im}));

endmodule

`default_nettype wire

// ==== hdl/escape_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module escape_core
    import mandel_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    point_job_if.core job,
    output logic     done,
    output iter_t    done_iter
);

    core_state_e state;
    fix_t        c_re, c_im;
    fix_t        z_re, z_im;
    iter_t       iter;      // Updates applied so far

    wide_t re_sq;
    wide_t im_sq;
    wide_t re_im;
    wide_t mag2;

    assign job.ready = (state == CORE_IDLE);

    // ========================================================================
    // Squares of the current z, all Q32.32
    // ========================================================================
    assign re_sq = wide_t'(z_re) * wide_t'(z_re);
    assign im_sq = wide_t'(z_im) * wide_t'(z_im);
    assign re_im = wide_t'(z_re) * wide_t'(z_im);
    assign mag2  = re_sq + im_sq;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= CORE_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                CORE_IDLE: begin
                    if (job.valid) begin
                        state <= CORE_ITER;
                    end
                end
                CORE_ITER: begin
                    if ((mag2 > ESCAPE_LIMIT) || (iter == iter_t'(MAX_ITER - 1))) begin
                        done  <= 1'b1;
                        state <= CORE_IDLE;
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job.valid && job.ready) begin
            c_re <= job.c_re;
            c_im <= job.c_im;
            z_re <= '0;
            z_im <= '0;
            iter <= '0;
        end else if (state == CORE_ITER) begin
            if (mag2 > ESCAPE_LIMIT) begin
                done_iter <= iter;
            end else if (iter == iter_t'(MAX_ITER - 1)) begin
                done_iter <= 8'hFF;     // Interior clamps to 255
            end else begin
                z_re <= fix_t'((re_sq - im_sq) >>> FRAC_BITS) + c_re;
                z_im <= fix_t'(re_im >>> (FRAC_BITS - 1)) + c_im;    // 2*re*im
                iter <= iter + 1'b1;
            end
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done);

endmodule

`default_nettype wire

// ==== hdl/frame_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_sequencer
    import mandel_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   start_valid,
    output logic   start_ready,
    input  view_e  start_view,
    output view_e  frame_view,
    output logic   map_start,
    output logic   cnt_clear,
    output logic   cnt_advance,
    input  pix_x_t cnt_x,
    input  pix_y_t cnt_y,
    input  logic   cnt_last,
    input  logic   done,
    input  iter_t  done_iter,
    output logic   pix_valid,
    input  logic   pix_ready,
    output pix_x_t pix_x,
    output pix_y_t pix_y,
    output iter_t  pix_iter,
    output logic   pix_last
);

    seq_state_e state;

    assign start_ready = (state == SEQ_IDLE);
    assign map_start   = (state == SEQ_ISSUE);     // One cycle only
    assign pix_valid   = (state == SEQ_EMIT);
    assign cnt_clear   = start_valid && start_ready;
    assign cnt_advance = pix_valid && pix_ready && !pix_last;

    // ========================================================================
    // Frame FSM
    // ========================================================================
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= SEQ_IDLE;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start_valid) begin
                        state <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    state <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (done) begin
                        state <= SEQ_EMIT;
                    end
                end
                SEQ_EMIT: begin
                    if (pix_ready) begin
                        state <= pix_last ? SEQ_IDLE : SEQ_ISSUE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // View is held for the frame, result held until taken
    always_ff @(posedge clk) begin
        if (cnt_clear) begin
            frame_view <= start_view;
        end
        if ((state == SEQ_WAIT) && done) begin
            pix_x    <= cnt_x;      // Counter still points at the issued pixel
            pix_y    <= cnt_y;
            pix_iter <= done_iter;
            pix_last <= cnt_last;
        end
    end

    a_hold_under_backpressure: assert property (@(posedge clk) disable iff (!resetn)
        pix_valid && !pix_ready |=>
            pix_valid && $stable({pix_x, pix_y, pix_iter, pix_last}));

endmodule

`default_nettype wire

// ==== hdl/mandel_pkg.sv ====
`default_nettype none

package mandel_pkg;

    // ========================================================================
    // Frame geometry and iteration limit
    // ========================================================================
    localparam int FRAME_W   = 320;
    localparam int FRAME_H   = 240;
    localparam int MAX_ITER  = 256;
    localparam int FRAC_BITS = 16;      // Q16.16

    typedef logic signed [31:0] fix_t;  // Plane coordinates and z
    typedef logic signed [63:0] wide_t; // Q32.32 or range times pixel
    typedef logic [9:0]         pix_x_t;
    typedef logic [8:0]         pix_y_t;
    typedef logic [7:0]         iter_t;

    typedef enum logic [1:0] {
        VIEW_FULL      = 2'd0,
        VIEW_SEAHORSE  = 2'd1,
        VIEW_ELEPHANT  = 2'd2,
        VIEW_DEEP_TAIL = 2'd3
    } view_e;

    // ========================================================================
    // Viewport presets in Q16.16
    // ========================================================================
    // Whole set, [-2.0, 1.0] by [-1.2, 1.2]
    localparam fix_t FULL_X_MIN = -32'sd131072;
    localparam fix_t FULL_X_MAX =  32'sd65536;
    localparam fix_t FULL_Y_MIN = -32'sd78643;
    localparam fix_t FULL_Y_MAX =  32'sd78643;

    // Seahorse valley
    localparam fix_t SEAHORSE_X_MIN = -32'sd52428;  // -0.8
    localparam fix_t SEAHORSE_X_MAX = -32'sd45875;  // -0.7
    localparam fix_t SEAHORSE_Y_MIN =  32'sd3277;   //  0.05
    localparam fix_t SEAHORSE_Y_MAX =  32'sd9830;   //  0.15

    // Elephant valley
    localparam fix_t ELEPHANT_X_MIN = -32'sd49152;  // -0.75
    localparam fix_t ELEPHANT_X_MAX = -32'sd45875;
    localparam fix_t ELEPHANT_Y_MIN =  32'sd6554;
    localparam fix_t ELEPHANT_Y_MAX =  32'sd13107;  //  0.20

    // Narrow window on the tail
    localparam fix_t DEEP_TAIL_X_MIN = -32'sd48824;
    localparam fix_t DEEP_TAIL_X_MAX = -32'sd48129;
    localparam fix_t DEEP_TAIL_Y_MIN =  32'sd8192;  //  0.125
    localparam fix_t DEEP_TAIL_Y_MAX =  32'sd8847;

    // Bailout radius squared, 4.0 in Q32.32
    localparam wide_t ESCAPE_LIMIT = 64'sd4 <<< (2 * FRAC_BITS);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT,
        SEQ_EMIT
    } seq_state_e;

    typedef enum logic {
        CORE_IDLE,
        CORE_ITER
    } core_state_e;

endpackage

`default_nettype wire

// ==== hdl/mandel_renderer.sv ====
`timescale 1ns/100ps
`default_nettype none

module mandel_renderer
    import mandel_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   start_valid,
    output logic   start_ready,
    input  view_e  start_view,
    output logic   pix_valid,
    input  logic   pix_ready,
    output pix_x_t pix_x,
    output pix_y_t pix_y,
    output iter_t  pix_iter,
    output logic   pix_last
);

    view_e  frame_view;
    logic   map_start;
    logic   cnt_clear;
    logic   cnt_advance;
    pix_x_t cnt_x;
    pix_y_t cnt_y;
    logic   cnt_last;
    logic   done;
    iter_t  done_iter;

    point_job_if job_if ();     // Mapper to core

    frame_sequencer u_seq (
        .clk         (clk),
        .resetn      (resetn),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .start_view  (start_view),
        .frame_view  (frame_view),
        .map_start   (map_start),
        .cnt_clear   (cnt_clear),
        .cnt_advance (cnt_advance),
        .cnt_x       (cnt_x),
        .cnt_y       (cnt_y),
        .cnt_last    (cnt_last),
        .done        (done),
        .done_iter   (done_iter),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_iter    (pix_iter),
        .pix_last    (pix_last)
    );

    raster_counter u_cnt (
        .clk     (clk),
        .resetn  (resetn),
        .clear   (cnt_clear),
        .advance (cnt_advance),
        .x       (cnt_x),
        .y       (cnt_y),
        .last    (cnt_last)
    );

    coord_mapper u_map (
        .clk       (clk),
        .resetn    (resetn),
        .map_start (map_start),
        .map_x     (cnt_x),
        .map_y     (cnt_y),
        .view      (frame_view),
        .job       (job_if.mapper)
    );

    escape_core u_core (
        .clk       (clk),
        .resetn    (resetn),
        .job       (job_if.core),
        .done      (done),
        .done_iter (done_iter)
    );

endmodule

`default_nettype wire

// ==== hdl/point_job_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One mapped point c, handed from the mapper to the escape core
interface point_job_if
    import mandel_pkg::*;
();

    logic valid;
    logic ready;
    fix_t c_re;     // Q16.16
    fix_t c_im;

    modport mapper (
        output valid,
        output c_re,
        output c_im,
        input  ready
    );

    modport core (
        input  valid,
        input  c_re,
        input  c_im,
        output ready
    );

endinterface

`default_nettype wire

// ==== hdl/raster_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module raster_counter
    import mandel_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   clear,
    input  logic   advance,
    output pix_x_t x,
    output pix_y_t y,
    output logic   last
);

    logic x_end;

    assign x_end = (x == pix_x_t'(FRAME_W - 1));
    assign last  = x_end && (y == pix_y_t'(FRAME_H - 1));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            x <= '0;
            y <= '0;
        end else if (clear) begin
            x <= '0;
            y <= '0;
        end else if (advance) begin
            if (x_end) begin
                x <= '0;
                y <= y + 1'b1;  // Next row
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Sequencer has to stop at the final pixel rather than step past it
    a_no_step_past_end: assert property (@(posedge clk) disable iff (!resetn)
        advance |-> !last);

endmodule

`default_nettype wire

// ==== mandel_renderer.f ====
hdl/mandel_pkg.sv
hdl/point_job_if.sv
hdl/raster_counter.sv
hdl/frame_sequencer.sv
hdl/coord_mapper.sv
hdl/escape_core.sv
hdl/mandel_renderer.sv
verification/tb_clock_gen.sv
verification/mandel_renderer_tb.sv

// ==== verification/mandel_renderer_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mandel_renderer_tb
    import mandel_pkg::*;
();

    localparam int SEED          = 32'h1078;
    localparam int TWO_ROWS      = 2 * FRAME_W;
    localparam int XFER_TIMEOUT  = 2000;    // Cycles without any transfer
    localparam int START_TIMEOUT = 100;

    logic        clk;
    logic        gen_resetn;
    logic        soft_resetn;
    logic        dut_resetn;
    logic        start_valid;
    logic        start_ready;
    view_e       start_view;
    logic        pix_valid;
    logic        pix_ready;
    pix_x_t      pix_x;
    pix_y_t      pix_y;
    iter_t       pix_iter;
    logic        pix_last;

    // Checker state
    string       cur_test;
    view_e       cur_view;
    int          exp_x;
    int          exp_y;
    int          xfer_count;
    logic        held;
    logic [27:0] held_bus;      // {x, y, iter, last} seen while stalled
    logic        ready_random;
    logic        busy_check;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          errors_before;
    int          hold_cycles;

    tb_clock_gen clk_gen (
        .clk    (clk),
        .resetn (gen_resetn)
    );

    assign dut_resetn = gen_resetn && soft_resetn;  // Power-on or mid-run reset

    mandel_renderer uut (
        .clk         (clk),
        .resetn      (dut_resetn),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .start_view  (start_view),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_iter    (pix_iter),
        .pix_last    (pix_last)
    );

    // ========================================================================
    // Reference model, fixed-point escape time per pixel
    // ========================================================================
    function automatic int expected_iter(input view_e view, input int px, input int py);
        int     x_min;
        int     x_max;
        int     y_min;
        int     y_max;
        int     c_re;
        int     c_im;
        int     z_re;
        int     z_im;
        longint re_sq;
        longint im_sq;
        longint re_im;
        case (view)
            VIEW_FULL:     {x_min, x_max, y_min, y_max} =
                {-32'sd131072, 32'sd65536, -32'sd78643, 32'sd78643};
            VIEW_SEAHORSE: {x_min, x_max, y_min, y_max} =
                {-32'sd52428, -32'sd45875, 32'sd3277, 32'sd9830};
            VIEW_ELEPHANT: {x_min, x_max, y_min, y_max} =
                {-32'sd49152, -32'sd45875, 32'sd6554, 32'sd13107};
            default:       {x_min, x_max, y_min, y_max} =
                {-32'sd48824, -32'sd48129, 32'sd8192, 32'sd8847};
        endcase
        // Range times pixel, then a signed divide that truncates toward zero
        c_re = x_min + int'((longint'(x_max - x_min) * longint'(px)) / longint'(FRAME_W - 1));
        c_im = y_min + int'((longint'(y_max - y_min) * longint'(py)) / longint'(FRAME_H - 1));
        z_re = 0;
        z_im = 0;
        for (int n = 0; n < MAX_ITER; n++) begin
            re_sq = longint'(z_re) * longint'(z_re);
            im_sq = longint'(z_im) * longint'(z_im);
            re_im = longint'(z_re) * longint'(z_im);
            if (re_sq + im_sq > (longint'(4) <<< 32)) begin
                return n % 256;
            end
            if (n == MAX_ITER - 1) begin
                return 255;     // Interior point
            end
            z_re = int'((re_sq - im_sq) >>> 16) + c_re;
            z_im = int'(re_im >>> 15) + c_im;
        end
        return 255;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", what, expected, actual);
        end
    endtask

    // Output stream checker
    always @(posedge clk) begin
        if (!dut_resetn) begin
            held <= 1'b0;
        end else begin
            if (held) begin
                compare_value($sformatf("%s pix_valid held", cur_test), 1, pix_valid);
                compare_value($sformatf("%s outputs held", cur_test), held_bus,
                              {pix_x, pix_y, pix_iter, pix_last});
            end
            if (pix_valid && pix_ready) begin
                compare_value($sformatf("%s pix_x", cur_test), exp_x, pix_x);
                compare_value($sformatf("%s pix_y", cur_test), exp_y, pix_y);
                compare_value($sformatf("%s pix_iter (%0d,%0d)", cur_test, exp_x, exp_y),
                              expected_iter(cur_view, exp_x, exp_y), pix_iter);
                compare_value($sformatf("%s pix_last (%0d,%0d)", cur_test, exp_x, exp_y),
                              (exp_x == FRAME_W - 1) && (exp_y == FRAME_H - 1), pix_last);
                xfer_count <= xfer_count + 1;
                if (exp_x == FRAME_W - 1) begin
                    exp_x <= 0;
                    exp_y <= exp_y + 1;
                end else begin
                    exp_x <= exp_x + 1;
                end
            end
            if (pix_valid && !pix_ready) begin
                hold_cycles++;
            end
            if (busy_check) begin
                compare_value($sformatf("%s start_ready busy", cur_test), 0, start_ready);
            end
            held     <= pix_valid && !pix_ready;
            held_bus <= {pix_x, pix_y, pix_iter, pix_last};
        end
    end

    always @(posedge clk) begin
        if (ready_random) begin
            pix_ready <= (($urandom % 3) != 0);     // Ready about two cycles in three
        end else begin
            pix_ready <= 1'b1;
        end
    end

    function automatic string view_label(input view_e view);
        case (view)
            VIEW_SEAHORSE:  return "seahorse_rows";
            VIEW_ELEPHANT:  return "elephant_rows";
            VIEW_DEEP_TAIL: return "deep_tail_rows";
            default:        return "full_rows";
        endcase
    endfunction

    task automatic arm_check(input string name, input view_e view);
        cur_test      = name;
        cur_view      = view;
        errors_before = errors;
        exp_x      <= 0;
        exp_y      <= 0;
        xfer_count <= 0;
    endtask

    task automatic start_frame(input view_e view);
        int waited;
        waited = 0;
        @(posedge clk);
        start_valid <= 1'b1;
        start_view  <= view;
        @(posedge clk);
        while (!start_ready && waited < START_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!start_ready) begin
            errors++;
            $display("Timeout in %s, the start request was never accepted", cur_test);
        end
        start_valid <= 1'b0;
    endtask

    task automatic wait_transfers(input int n);
        int idle;
        int seen;
        idle = 0;
        seen = xfer_count;
        while (xfer_count < n && idle < XFER_TIMEOUT) begin
            @(posedge clk);
            if (xfer_count != seen) begin
                seen = xfer_count;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (xfer_count < n) begin
            errors++;
            $display("Timeout in %s, only %0d of %0d results arrived", cur_test, xfer_count, n);
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        soft_resetn <= 1'b0;
        repeat (2) @(posedge clk);
        soft_resetn <= 1'b1;
    endtask

    task automatic report_test();
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %s finished, no errors", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s finished, %0d errors", cur_test, errors - errors_before);
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        int waited;
        void'($urandom(SEED));
        start_valid  <= 1'b0;
        start_view   <= VIEW_FULL;
        pix_ready    <= 1'b0;
        soft_resetn  <= 1'b1;
        ready_random = 1'b0;
        busy_check   = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hold_cycles  = 0;
        arm_check("reset_state", VIEW_FULL);

        waited = 0;
        while (gen_resetn !== 1'b1 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (gen_resetn !== 1'b1) begin
            errors++;
            $display("Reset was never released by the clock generator");
        end
        @(posedge clk);
        compare_value("reset_state start_ready", 1, start_ready);
        compare_value("reset_state pix_valid", 0, pix_valid);
        report_test();

        // Whole frame with the sink always ready
        arm_check("full_frame", VIEW_FULL);
        start_frame(VIEW_FULL);
        wait_transfers(FRAME_W * FRAME_H);
        compare_value("full_frame start_ready after frame", 1, start_ready);
        compare_value("full_frame pix_valid after frame", 0, pix_valid);
        report_test();

        for (int i = 1; i < 4; i++) begin
            arm_check(view_label(view_e'(i)), view_e'(i));
            start_frame(view_e'(i));
            wait_transfers(TWO_ROWS);
            reset_dut();
            report_test();
        end

        // Random back-pressure on the output stream
        arm_check("backpressure", VIEW_SEAHORSE);
        hold_cycles  = 0;
        ready_random <= 1'b1;
        start_frame(VIEW_SEAHORSE);
        wait_transfers(TWO_ROWS);
        ready_random <= 1'b0;
        if (hold_cycles == 0) begin
            errors++;
            $display("Test backpressure never saw a result held by a stalled sink");
        end
        reset_dut();
        report_test();

        // A second start request during a frame must be ignored
        arm_check("restart_ignored", VIEW_DEEP_TAIL);
        start_frame(VIEW_DEEP_TAIL);
        @(posedge clk);
        busy_check  <= 1'b1;
        start_valid <= 1'b1;
        start_view  <= VIEW_FULL;
        wait_transfers(TWO_ROWS);
        busy_check  <= 1'b0;
        start_valid <= 1'b0;
        reset_dut();
        report_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    localparam real HALF_PERIOD = 10.0;     // 20 ns clock

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset held low over the first two rising edges
    initial begin
        resetn <= 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire
